/* beat_fifo.sv */
`timescale 1ns/1ps

`include "tnn_defs.svh"

module beat_fifo #(
   parameter int DEPTH = `FIFO_DEPTH
)
(
   input  logic           clk,
   input  logic           rst_n,

   // write side
   input  logic           in_valid,
   output logic           in_ready,
   input  tnn_pkg::beat_t in_data,

   // read side
   output logic           out_valid,
   input  logic           out_ready,
   output tnn_pkg::beat_t out_data
);

   import tnn_pkg::*;

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   beat_t            mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic [CNT_W-1:0] count_next;
   logic             push;
   logic             pop;

   assign push = in_valid && in_ready;
   assign pop  = out_valid && out_ready;

   // occupancy after this edge
   always_comb
   begin
      count_next = count;
      if (push && !pop)
         count_next = count + CNT_W'(1);
      else if (pop && !push)
         count_next = count - CNT_W'(1);
   end

   // ------------------------------------------------------------
   // pointers and flags
   // ------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         in_ready <= 1'b0;
      end
      else
      begin
         if (push)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
         if (pop)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
         count <= count_next;
         // registered so ready stays low through reset
         in_ready <= (count_next != CNT_W'(DEPTH));
      end
   end

   // storage
   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= in_data;
   end

   assign out_valid = (count != '0);
   assign out_data  = mem[rd_ptr];

endmodule

/* run.sh */
#!/bin/bash
# build and run the testbench, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_tnn -o sim_tnn \
   && ./obj_dir/sim_tnn > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TB FAILED" sim.log && exit 1
grep -q "TB PASSED" sim.log || exit 1

/* stage_pipe.sv */
`timescale 1ns/1ps

module stage_pipe #(
   parameter int WIDTH  = 1,
   parameter int STAGES = 1
)
(
   input  logic             clk,
   input  logic [WIDTH-1:0] in_bus,
   output logic [WIDTH-1:0] out_bus
);

   // register chain, entry 0 is closest to the input
   logic [WIDTH-1:0] pipe_q [STAGES];

   always_ff @(posedge clk)
   begin
      pipe_q[0] <= in_bus;
      for (int i = 1; i < STAGES; i++)
      begin
         pipe_q[i] <= pipe_q[i-1];
      end
   end

   // in_bus shows up here STAGES cycles later
   assign out_bus = pipe_q[STAGES-1];

endmodule

/* stat_regs.sv */
`timescale 1ns/1ps

`include "tnn_defs.svh"

module stat_regs
(
   input  logic                    clk,
   input  logic                    rst_n,

   // delayed request from the request pipe
   input  logic                    req_wr,
   input  logic                    req_rd,
   input  logic [`STAT_ADDR_W-1:0] req_addr,
   input  logic [`STAT_DATA_W-1:0] req_wdata,

   // goes back through the acknowledge pipe
   output logic                    ack,
   output logic [`STAT_DATA_W-1:0] ack_rdata,

   output tnn_pkg::weights_t       weights,
   input  logic [31:0]             beat_count
);

   logic [`STAT_DATA_W-1:0] rd_mux;
   logic                    wr_weights;

   // writes to ADDR_BEATS or unknown addresses are dropped
   assign wr_weights = req_wr && (req_addr == `ADDR_WEIGHTS);

   // ------------------------------------------------------------
   // read decode
   // ------------------------------------------------------------
   always_comb
   begin
      case (req_addr)
         `ADDR_WEIGHTS: rd_mux = weights;
         `ADDR_BEATS:   rd_mux = beat_count;
         default:       rd_mux = '0;
      endcase
   end

   // ------------------------------------------------------------
   // weight register and acknowledge
   // ------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         weights <= '0;
         ack     <= 1'b0;
      end
      else
      begin
         if (wr_weights)
            weights <= req_wdata;
         // one-cycle ack, the cycle after the request arrives
         ack <= req_wr || req_rd;
      end
   end

   // read data rides along with the ack
   always_ff @(posedge clk)
   begin
      if (req_rd)
         ack_rdata <= rd_mux;
      else
         ack_rdata <= '0;
   end

endmodule

/* tb_tnn.sv */
`timescale 1ns/1ps

`include "tnn_defs.svh"

module tb_tnn;

   import tnn_pkg::*;

   localparam int ROUNDS      = 2;
   localparam int ROUND_BEATS = 20;
   localparam int BP_BEATS    = 40;
   // FIFO plus both engine stages
   localparam int FILL_BEATS  = `FIFO_DEPTH + 2;
   localparam int NUM_REQS    = 10;
   localparam int NUM_ITEMS   = ROUNDS * ROUND_BEATS + BP_BEATS + FILL_BEATS + 1 + NUM_REQS;
   localparam int TIMEOUT_CYC = 16 + NUM_ITEMS * 40;

   logic                    clk;
   logic                    pipe_rst_n;
   logic                    in_valid;
   logic                    in_ready;
   beat_t                   in_data;
   logic                    out_valid;
   logic                    out_ready;
   beat_t                   out_data;
   logic                    stat_wr;
   logic                    stat_rd;
   logic [`STAT_ADDR_W-1:0] stat_addr;
   logic [`STAT_DATA_W-1:0] stat_wdata;
   logic                    stat_ack;
   logic [`STAT_DATA_W-1:0] stat_rdata;

   int                      bp_mode;
   int                      err_mark;
   int                      tests_done;

   tnn_top UUT (.*);

   tb_tnn_checker chk (.*);

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // out_ready per bp_mode, 0 always ready, 1 random, 2 stalled
   task automatic next_cycle();
      @(negedge clk);
      case (bp_mode)
         0:       out_ready = 1'b1;
         1:       out_ready = ($urandom % 2) == 0;
         default: out_ready = 1'b0;
      endcase
   endtask

   function automatic beat_t random_beat();
      beat_t b;
      for (int i = 0; i < `NUM_LANES; i++)
         b[i*`LANE_W +: `LANE_W] = $urandom;
      return b;
   endfunction

   task automatic send_beat(input beat_t b);
      in_valid = 1'b1;
      in_data  = b;
      while (!in_ready)
         next_cycle();
      next_cycle();
      in_valid = 1'b0;
   endtask

   // one request pulse, then wait for its ack
   task automatic reg_access(input logic wr, input logic [7:0] addr, input logic [31:0] data);
      stat_wr    = wr;
      stat_rd    = !wr;
      stat_addr  = addr;
      stat_wdata = data;
      next_cycle();
      stat_wr = 1'b0;
      stat_rd = 1'b0;
      while (!stat_ack)
         next_cycle();
   endtask

   task automatic wait_drain();
      while (chk.outstanding != 0)
         next_cycle();
   endtask

   task automatic end_test(input string name);
      tests_done++;
      $display("test %0d %s finished with %0d errors", tests_done, name, chk.errors - err_mark);
      err_mark = chk.errors;
   endtask

   // ------------------------------------------------------------
   // stimulus
   // ------------------------------------------------------------
   initial
   begin : stimulus
      void'($urandom(34920));
      bp_mode    = 0;
      err_mark   = 0;
      tests_done = 0;
      pipe_rst_n = 1'b0;
      in_valid   = 1'b0;
      in_data    = '0;
      out_ready  = 1'b1;
      stat_wr    = 1'b0;
      stat_rd    = 1'b0;
      stat_addr  = '0;
      stat_wdata = '0;
      repeat (16)
         next_cycle();
      pipe_rst_n = 1'b1;

      // slices come out of reset, registers read zero
      repeat (`RST_STAGES + 2)
         next_cycle();
      reg_access(1'b0, `ADDR_WEIGHTS, '0);
      reg_access(1'b0, `ADDR_BEATS, '0);
      end_test("reset state");

      reg_access(1'b1, `ADDR_WEIGHTS, $urandom);
      reg_access(1'b0, `ADDR_WEIGHTS, '0);
      reg_access(1'b0, 8'($urandom_range(255, 5)), '0);
      end_test("register access");

      // lane 15 always gets the unused code 11
      for (int r = 0; r < ROUNDS; r++)
      begin
         reg_access(1'b1, `ADDR_WEIGHTS, {2'b11, 30'($urandom)});
         repeat (ROUND_BEATS)
            send_beat(random_beat());
         wait_drain();
      end
      end_test("random weights");

      bp_mode = 1;
      repeat (BP_BEATS)
         send_beat(random_beat());
      wait_drain();
      bp_mode   = 2;
      out_ready = 1'b0;
      repeat (FILL_BEATS)
         send_beat(random_beat());
      // one more beat waits against the full FIFO
      in_valid = 1'b1;
      in_data  = random_beat();
      repeat (6)
         next_cycle();
      bp_mode = 0;
      while (!in_ready)
         next_cycle();
      next_cycle();
      in_valid = 1'b0;
      wait_drain();
      end_test("back-pressure");

      reg_access(1'b0, `ADDR_BEATS, '0);
      reg_access(1'b1, `ADDR_BEATS, $urandom);
      reg_access(1'b0, `ADDR_BEATS, '0);
      end_test("beat counter");

      $display("tests %0d, checks %0d, errors %0d", tests_done, chk.checks, chk.errors);
      if (chk.errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

   initial
   begin : watchdog
      repeat (TIMEOUT_CYC)
         @(posedge clk);
      $display("watchdog expired, run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("TB FAILED");
      $finish;
   end

endmodule

/* tb_tnn_checker.sv */
`timescale 1ns/1ps

`include "tnn_defs.svh"

module tb_tnn_checker
(
   input logic                    clk,
   input logic                    pipe_rst_n,
   input logic                    in_valid,
   input logic                    in_ready,
   input tnn_pkg::beat_t          in_data,
   input logic                    out_valid,
   input logic                    out_ready,
   input tnn_pkg::beat_t          out_data,
   input logic                    stat_wr,
   input logic                    stat_rd,
   input logic [`STAT_ADDR_W-1:0] stat_addr,
   input logic [`STAT_DATA_W-1:0] stat_wdata,
   input logic                    stat_ack,
   input logic [`STAT_DATA_W-1:0] stat_rdata
);

   import tnn_pkg::*;

   int          errors      = 0;
   int          checks      = 0;
   int          outstanding = 0;
   int          cyc         = 0;
   int          rel_cyc     = 0;
   bit          stream_up   = 1'b0;
   bit          stalled     = 1'b0;
   beat_t       stall_data;
   logic [31:0] model_w     = '0;
   logic [31:0] model_count = '0;

   // expected output beats in order, and pending register acks
   beat_t       exp_q [$];
   int          ack_due [$];
   bit          ack_rd [$];
   logic [31:0] ack_exp [$];

   // zero, pass or negate each lane, code 11 counts as zero
   function automatic beat_t apply_weights(input beat_t b, input logic [31:0] w);
      beat_t       r;
      logic [31:0] x;
      for (int i = 0; i < `NUM_LANES; i++)
      begin
         x = b[i*`LANE_W +: `LANE_W];
         if (w[2*i +: 2] == 2'b01)
            r[i*`LANE_W +: `LANE_W] = x;
         else if (w[2*i +: 2] == 2'b10)
            r[i*`LANE_W +: `LANE_W] = ~x + 32'd1;
         else
            r[i*`LANE_W +: `LANE_W] = '0;
      end
      return r;
   endfunction

   task automatic report(input string msg);
      errors++;
      $display("%s at cycle %0d", msg, cyc);
   endtask

   // ------------------------------------------------------------
   // stream path
   // ------------------------------------------------------------
   task automatic check_stream();
      beat_t exp;
      if (in_ready)
         stream_up = 1'b1;
      // a full FIFO means both engine stages are full too
      if (stream_up && !in_ready && exp_q.size() != `FIFO_DEPTH + 2)
         report($sformatf("in_ready low with %0d beats waiting", exp_q.size()));
      if (in_ready && exp_q.size() >= `FIFO_DEPTH + 2)
         report("in_ready still high with the FIFO full");
      if (stalled && !out_valid)
         report("out_valid dropped while the output was stalled");
      else if (stalled && out_data !== stall_data)
         report($sformatf("CHECK FAILED out_data: got %h, expected %h", out_data, stall_data));
      stalled    = out_valid && !out_ready;
      stall_data = out_data;
      if (out_valid && out_ready)
      begin
         checks++;
         model_count++;
         if (exp_q.size() == 0)
            report("output beat with no matching input beat");
         else
         begin
            exp = exp_q.pop_front();
            if (out_data !== exp)
               report($sformatf("CHECK FAILED out_data: got %h, expected %h", out_data, exp));
         end
      end
      if (in_valid && in_ready)
         exp_q.push_back(apply_weights(in_data, model_w));
      outstanding = exp_q.size();
   endtask

   // ------------------------------------------------------------
   // register channel
   // ------------------------------------------------------------
   task automatic check_regs();
      if (ack_due.size() != 0 && ack_due[0] == cyc)
      begin
         checks++;
         if (!stat_ack)
            report("stat_ack missing 17 cycles after its request");
         else if (ack_rd[0] && stat_rdata !== ack_exp[0])
            report($sformatf("CHECK FAILED stat_rdata: got %h, expected %h",
               stat_rdata, ack_exp[0]));
         void'(ack_due.pop_front());
         void'(ack_rd.pop_front());
         void'(ack_exp.pop_front());
      end
      else if (stat_ack)
         report("stat_ack with no request pending");
      if (stat_wr || stat_rd)
      begin
         // out through the request pipe, one cycle in the block, back again
         ack_due.push_back(cyc + 2 * `STAT_STAGES + 1);
         ack_rd.push_back(stat_rd);
         if (stat_addr == `ADDR_WEIGHTS)
            ack_exp.push_back(model_w);
         else if (stat_addr == `ADDR_BEATS)
            ack_exp.push_back(model_count);
         else
            ack_exp.push_back('0);
         if (stat_wr && stat_addr == `ADDR_WEIGHTS)
            model_w = stat_wdata;
      end
   endtask

   always @(posedge clk)
   begin
      cyc++;
      if (!pipe_rst_n)
         rel_cyc = 0;
      else
      begin
         // slices still held in reset right after release
         if (rel_cyc < `RST_STAGES)
         begin
            checks++;
            if (in_ready !== 1'b0 || out_valid !== 1'b0 || stat_ack !== 1'b0)
               report("in_ready, out_valid or stat_ack high before the slices left reset");
         end
         rel_cyc++;
         check_stream();
         check_regs();
      end
   end

endmodule

/* ternary_engine.sv */
`timescale 1ns/1ps

`include "tnn_defs.svh"

module ternary_engine
(
   input  logic              clk,
   input  logic              rst_n,

   input  logic              in_valid,
   output logic              in_ready,
   input  tnn_pkg::beat_t    in_data,

   input  tnn_pkg::weights_t weights,

   output logic              out_valid,
   input  logic              out_ready,
   output tnn_pkg::beat_t    out_data,

   output logic [31:0]       beat_count
);

   import tnn_pkg::*;

   // stage one holds the raw beat and the weights it entered with
   logic     s1_valid;
   beat_t    s1_data;
   weights_t s1_weights;

   // stage two holds the finished beat
   logic     s2_valid;
   beat_t    s2_data;

   beat_t    lane_prod;
   logic     s1_adv;
   logic     in_fire;

   // a stage moves on when the next one is empty or draining
   assign s1_adv   = s1_valid && (!s2_valid || out_ready);
   assign in_ready = !s1_valid || s1_adv;
   assign in_fire  = in_valid && in_ready;

   // ------------------------------------------------------------
   // lane-wise ternary multiply
   // ------------------------------------------------------------
   always_comb
   begin : lane_mult
      lane_t   lane_in;
      weight_e code;
      lane_prod = '0;
      for (int i = 0; i < `NUM_LANES; i++)
      begin
         lane_in = s1_data[i*`LANE_W +: `LANE_W];
         code    = weight_e'(s1_weights[2*i +: 2]);
         case (code)
            W_POS:   lane_prod[i*`LANE_W +: `LANE_W] = lane_in;
            // two's complement, wraps modulo 2^32
            W_NEG:   lane_prod[i*`LANE_W +: `LANE_W] = '0 - lane_in;
            default: lane_prod[i*`LANE_W +: `LANE_W] = '0;
         endcase
      end
   end

   // ------------------------------------------------------------
   // pipeline control
   // ------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         s1_valid   <= 1'b0;
         s2_valid   <= 1'b0;
         beat_count <= '0;
      end
      else
      begin
         if (in_fire)
            s1_valid <= 1'b1;
         else if (s1_adv)
            s1_valid <= 1'b0;

         if (s1_adv)
            s2_valid <= 1'b1;
         else if (out_ready)
            s2_valid <= 1'b0;

         if (out_valid && out_ready)
            beat_count <= beat_count + 32'd1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (in_fire)
      begin
         s1_data    <= in_data;
         s1_weights <= weights;
      end
      if (s1_adv)
         s2_data <= lane_prod;
   end

   assign out_valid = s2_valid;
   assign out_data  = s2_data;

endmodule

/* tnn_assert.sv */
`timescale 1ns/1ps

`include "tnn_defs.svh"

module tnn_assert
(
   input logic           clk,
   input logic           pipe_rst_n,
   input logic           in_valid,
   input logic           in_ready,
   input tnn_pkg::beat_t in_data,
   input logic           out_valid,
   input logic           out_ready,
   input tnn_pkg::beat_t out_data,
   input logic           stat_wr,
   input logic           stat_rd,
   input logic           stat_ack
);

   // a stalled input beat stays in place
   in_hold: assert property (@(posedge clk) disable iff (!pipe_rst_n)
      in_valid && !in_ready |=> in_valid && $stable(in_data))
      else $error("input beat changed while stalled");

   out_hold: assert property (@(posedge clk) disable iff (!pipe_rst_n)
      out_valid && !out_ready |=> out_valid && $stable(out_data))
      else $error("output beat changed while stalled");

   ack_pulse: assert property (@(posedge clk) disable iff (!pipe_rst_n)
      stat_ack |=> !stat_ack)
      else $error("stat_ack longer than one cycle");

   // out through the request pipe, one cycle in the block, back again
   ack_delay: assert property (@(posedge clk) disable iff (!pipe_rst_n)
      stat_ack == $past(stat_wr || stat_rd, 2 * `STAT_STAGES + 1))
      else $error("stat_ack not exactly 17 cycles after its request");

endmodule

bind tnn_top tnn_assert assert_inst (.*);

/* tnn_defs.svh */
`ifndef TNN_DEFS_SVH
`define TNN_DEFS_SVH

// stream geometry
`define BEAT_W      512
`define LANE_W      32
`define NUM_LANES   16

// beats buffered ahead of the engine
`define FIFO_DEPTH  16

// fixed delay stages for slice resets and the register channel
`define RST_STAGES  4
`define STAT_STAGES 8

// register channel
`define STAT_ADDR_W  8
`define STAT_DATA_W  32
`define ADDR_WEIGHTS 8'h00
`define ADDR_BEATS   8'h04

`endif

/* tnn_pkg.sv */
`include "tnn_defs.svh"

package tnn_pkg;

   // ------------------------------------------------------------
   // ternary weight codes
   // ------------------------------------------------------------

   // code 2'b11 is not listed and acts as zero
   typedef enum logic [1:0]
   {
      W_ZERO = 2'b00,
      W_POS  = 2'b01,
      W_NEG  = 2'b10
   } weight_e;

   // ------------------------------------------------------------
   // data types
   // ------------------------------------------------------------

   // one host beat, lane i sits at bits 32i+31 down to 32i
   typedef logic [`BEAT_W-1:0] beat_t;

   typedef logic [`LANE_W-1:0] lane_t;

   // lane i uses bits 2i+1 down to 2i
   typedef logic [2*`NUM_LANES-1:0] weights_t;

endpackage

/* tnn_top.sv */
`timescale 1ns/1ps

`include "tnn_defs.svh"

module tnn_top
(
   input  logic                    clk,
   input  logic                    pipe_rst_n,

   // host input stream
   input  logic                    in_valid,
   output logic                    in_ready,
   input  tnn_pkg::beat_t          in_data,

   // result stream
   output logic                    out_valid,
   input  logic                    out_ready,
   output tnn_pkg::beat_t          out_data,

   // register channel
   input  logic                    stat_wr,
   input  logic                    stat_rd,
   input  logic [`STAT_ADDR_W-1:0] stat_addr,
   input  logic [`STAT_DATA_W-1:0] stat_wdata,
   output logic                    stat_ack,
   output logic [`STAT_DATA_W-1:0] stat_rdata
);

   import tnn_pkg::*;

   localparam int REQ_W = 2 + `STAT_ADDR_W + `STAT_DATA_W;
   localparam int ACK_W = 1 + `STAT_DATA_W;

   logic                    eng_rst_n;
   logic                    stat_rst_n;

   logic                    fifo_valid;
   logic                    fifo_ready;
   beat_t                   fifo_data;

   weights_t                weights;
   logic [31:0]             beat_count;

   logic                    req_wr_q;
   logic                    req_rd_q;
   logic [`STAT_ADDR_W-1:0] req_addr_q;
   logic [`STAT_DATA_W-1:0] req_wdata_q;
   logic                    ack_q;
   logic [`STAT_DATA_W-1:0] ack_rdata_q;

   // ------------------------------------------------------------
   // slice resets
   // ------------------------------------------------------------
   stage_pipe #(.WIDTH(1), .STAGES(`RST_STAGES)) eng_rst_pipe (
      .clk     (clk),
      .in_bus  (pipe_rst_n),
      .out_bus (eng_rst_n)
   );

   stage_pipe #(.WIDTH(1), .STAGES(`RST_STAGES)) stat_rst_pipe (
      .clk     (clk),
      .in_bus  (pipe_rst_n),
      .out_bus (stat_rst_n)
   );

   // ------------------------------------------------------------
   // stream path
   // ------------------------------------------------------------
   beat_fifo #(.DEPTH(`FIFO_DEPTH)) fifo (
      .clk       (clk),
      .rst_n     (eng_rst_n),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_data   (in_data),
      .out_valid (fifo_valid),
      .out_ready (fifo_ready),
      .out_data  (fifo_data)
   );

   ternary_engine engine (
      .clk        (clk),
      .rst_n      (eng_rst_n),
      .in_valid   (fifo_valid),
      .in_ready   (fifo_ready),
      .in_data    (fifo_data),
      .weights    (weights),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out_data   (out_data),
      .beat_count (beat_count)
   );

   // ------------------------------------------------------------
   // register channel, 8 stages each way
   // ------------------------------------------------------------
   stage_pipe #(.WIDTH(REQ_W), .STAGES(`STAT_STAGES)) req_pipe (
      .clk     (clk),
      .in_bus  ({stat_wr, stat_rd, stat_addr, stat_wdata}),
      .out_bus ({req_wr_q, req_rd_q, req_addr_q, req_wdata_q})
   );

   stat_regs regs (
      .clk        (clk),
      .rst_n      (stat_rst_n),
      .req_wr     (req_wr_q),
      .req_rd     (req_rd_q),
      .req_addr   (req_addr_q),
      .req_wdata  (req_wdata_q),
      .ack        (ack_q),
      .ack_rdata  (ack_rdata_q),
      .weights    (weights),
      .beat_count (beat_count)
   );

   stage_pipe #(.WIDTH(ACK_W), .STAGES(`STAT_STAGES)) ack_pipe (
      .clk     (clk),
      .in_bus  ({ack_q, ack_rdata_q}),
      .out_bus ({stat_ack, stat_rdata})
   );

endmodule

/* verilog.f */
+incdir+.
tnn_pkg.sv
stage_pipe.sv
beat_fifo.sv
ternary_engine.sv
stat_regs.sv
tnn_top.sv
tb_tnn_checker.sv
tnn_assert.sv
tb_tnn.sv
